//--- files.f
hdl/mem_pkg.sv
hdl/mem_stage.sv
hdl/mem_port_arb.sv
hdl/clint_regs.sv
hdl/mem_subsys_top.sv
bench/mem_checker.sv
bench/tb_mem_subsys.sv

//--- Makefile
.PHONY: sim clean

sim:
	verilator --binary --timing --assert -f files.f --top-module tb_mem_subsys -o tb_sim
	./obj_dir/tb_sim | tee /dev/stderr | grep -q "RESULT: PASS"

clean:
	rm -rf obj_dir

//--- bench/tb_mem_subsys.sv
/* Random instructions from a fixed seed; the memories answer from byte maps
   with random ack delay. Timer loads use LD only. */
`timescale 1ns/1ps

module tb_mem_subsys import mem_pkg::*; ();

  logic        clk;
  logic        rst;
  logic        i_ex_req;
  ex_pkt_t     i_ex_pkt;
  logic        o_ex_ack;
  logic        o_wb_req;
  wb_pkt_t     o_wb_pkt;
  logic        i_wb_ack;
  logic        o_dcache_req;
  mem_req_t    o_dcache_req_pkt;
  logic        i_dcache_ack;
  logic [63:0] i_dcache_rdata;
  logic        o_nocache_req;
  mem_req_t    o_nocache_req_pkt;
  logic        i_nocache_ack;
  logic [63:0] i_nocache_rdata;
  logic        o_timer_irq;
  int          chk_errors;
  int          chk_handshakes;
  logic [63:0] last_wdata;

  int          seed = 71130;
  int          resp_seed = 71130 + 1;
  int          issued = 0;
  int          tb_errors = 0;
  int          stall_pct = 25;
  int          dc_wait = 0;
  int          nc_wait = 0;
  logic [63:0] mtime_seen = 64'd0;
  logic [63:0] cmp_val = '1;
  logic [7:0]  model_mem [logic [63:0]];
  logic [7:0]  dev_mem [logic [63:0]];
  mem_op_e     load_ops [7] = '{LB, LBU, LH, LHU, LW, LWU, LD};
  mem_op_e     store_ops [4] = '{SB, SH, SW, SD};

  mem_subsys_top #(.TIMER_DIV(1)) DUT (.*);

  mem_checker u_chk (
    .clk(clk), .rst(rst), .i_ex_ack(o_ex_ack),
    .i_wb_req(o_wb_req), .i_wb_pkt(o_wb_pkt), .i_wb_ack(i_wb_ack),
    .i_dc_req(o_dcache_req), .i_dc_pkt(o_dcache_req_pkt), .i_dc_ack(i_dcache_ack),
    .i_nc_req(o_nocache_req), .i_nc_pkt(o_nocache_req_pkt), .i_nc_ack(i_nocache_ack),
    .o_errors(chk_errors), .o_handshakes(chk_handshakes), .o_last_wdata(last_wdata)
  );

  initial begin
    clk = 1'b0;
    forever #2 clk = ~clk;
  end

  // untouched bytes follow this pattern
  function automatic logic [7:0] fill_byte(input logic [63:0] a);
    return a[7:0] ^ a[15:8] ^ a[23:16] ^ a[31:24] ^ a[39:32] ^ a[47:40] ^
           a[55:48] ^ a[63:56] ^ 8'h3c;
  endfunction

  function automatic logic [63:0] read_bytes(input bit dev, input logic [63:0] a);
    logic [63:0] v;
    logic [63:0] b;
    for (int n = 0; n < 8; n++) begin
      b = a + 64'(n);
      if (dev) begin
        v[8*n +: 8] = dev_mem.exists(b) ? dev_mem[b] : fill_byte(b);
      end else begin
        v[8*n +: 8] = model_mem.exists(b) ? model_mem[b] : fill_byte(b);
      end
    end
    return v;
  endfunction

  function automatic int access_bytes(input mem_op_e op);
    case (op)
      LH, LHU, SH: return 2;
      LW, LWU, SW: return 4;
      LD, SD:      return 8;
      default:     return 1;
    endcase
  endfunction

  function automatic logic [63:0] extend(input mem_op_e op, input logic [63:0] raw);
    case (op)
      LB:      return {{56{raw[7]}}, raw[7:0]};
      LBU:     return {56'd0, raw[7:0]};
      LH:      return {{48{raw[15]}}, raw[15:0]};
      LHU:     return {48'd0, raw[15:0]};
      LW:      return {{32{raw[31]}}, raw[31:0]};
      LWU:     return {32'd0, raw[31:0]};
      default: return raw;
    endcase
  endfunction

  function automatic logic [7:0] data_region();
    case ({$random(seed)} % 3)
      0:       return REGION_DCACHE;
      1:       return REGION_NOCACHE_A;
      default: return REGION_NOCACHE_B;
    endcase
  endfunction

  // aligned address in a 64-byte window of the region
  function automatic logic [63:0] rand_addr(input logic [7:0] region, input int sz);
    int off;
    off = ({$random(seed)} % 64) & ~(sz - 1);
    return {32'd0, region, 16'd0, 8'(off)};
  endfunction

  function automatic ex_pkt_t make_pkt(input mem_op_e op, input logic [63:0] addr);
    ex_pkt_t p;
    logic [63:0] k;
    k          = 64'({$random(seed)} % 32);
    p.pc       = {$random(seed), $random(seed)};
    p.inst     = $random(seed);
    p.rd       = 5'($random(seed));
    p.rd_wen   = 1'($random(seed));
    p.rd_wdata = {$random(seed), $random(seed)};
    p.nocmt    = 1'($random(seed));
    p.skipcmt  = 1'($random(seed));
    p.op       = op;
    p.op1      = addr - k;
    p.op2      = {$random(seed), $random(seed)};
    p.op3      = k;
    return p;
  endfunction

  task automatic timeout(input string what);
    $display("timeout while waiting for %s at %0t", what, $time);
    $display("RESULT: FAIL");
    $finish;
  endtask

  // predicts the result, then hands the packet over on the execute handshake
  task automatic issue(input ex_pkt_t p);
    logic [63:0] addr;
    logic [63:0] sd;
    logic [7:0]  region;
    wb_pkt_t     e;
    mem_req_t    r;
    bit          ld;
    bit          st;
    bit          ge;
    int          sz;
    int          n;
    addr   = p.op1 + p.op3;
    region = addr[31:24];
    ld     = p.op inside {LB, LBU, LH, LHU, LW, LWU, LD};
    st     = p.op inside {SB, SH, SW, SD};
    sz     = access_bytes(p.op);
    sd     = (sz == 8) ? p.op2 : p.op2 & ((64'd1 << (8 * sz)) - 64'd1);
    e      = '{pc: p.pc, inst: p.inst, rd: p.rd, rd_wen: p.rd_wen, rd_wdata: p.rd_wdata,
               nocmt: p.nocmt, skipcmt: p.skipcmt};
    ge     = 1'b0;
    if ((ld || st) && region inside {REGION_DCACHE, REGION_NOCACHE_A, REGION_NOCACHE_B}) begin
      r.addr  = addr;
      r.op    = st;
      r.bytes = 3'(sz - 1);
      r.wdata = sd;
      u_chk.push_port(r, region == REGION_DCACHE);
      if (st) begin
        for (int b = 0; b < sz; b++) begin
          model_mem[addr + 64'(b)] = sd[8*b +: 8];
        end
      end else begin
        e.rd_wdata = extend(p.op, read_bytes(1'b0, addr));
      end
    end else if ((ld || st) && region == REGION_CLINT) begin
      e.skipcmt = 1'b1;
      if (st && addr[15:0] == CLINT_MTIMECMP_OFS) begin
        cmp_val = sd;
      end
      if (ld) begin
        e.rd_wdata = (addr[15:0] == CLINT_MTIMECMP_OFS) ? cmp_val : mtime_seen;
        ge         = (addr[15:0] == CLINT_MTIME_OFS);
      end
    end else if (ld) begin
      e.rd_wdata = 64'd0;
    end
    u_chk.push_result(e, ge);
    i_ex_req = 1'b1;
    i_ex_pkt = p;
    n = 0;
    while (!o_ex_ack) begin
      @(posedge clk);
      #1;
      n++;
      if (n > 300) timeout("o_ex_ack");
    end
    @(posedge clk);
    #1;
    i_ex_req = 1'b0;
    issued++;
  endtask

  task automatic wait_idle();
    int n;
    n = 0;
    while (chk_handshakes < issued) begin
      @(posedge clk);
      #1;
      n++;
      if (n > 500) timeout("write-back of all issued instructions");
    end
  endtask

  task automatic report(input int num, input string name);
    $display("test %0d %s finished, errors so far %0d", num, name, chk_errors + tb_errors);
  endtask

  task automatic random_mix(input int count);
    mem_op_e op;
    repeat (count) begin
      case ({$random(seed)} % 5)
        0: op = ALU;
        1, 2: op = load_ops[{$random(seed)} % 7];
        default: op = store_ops[{$random(seed)} % 4];
      endcase
      issue(make_pkt(op, rand_addr(data_region(), access_bytes(op))));
    end
  endtask

  // memory responders and write-back stalls
  always @(posedge clk) begin
    #1;
    i_wb_ack = ({$random(resp_seed)} % 100) >= stall_pct;
    if (i_dcache_ack) begin
      i_dcache_ack = 1'b0;
    end else if (o_dcache_req) begin
      if (dc_wait == 0) begin
        serve(o_dcache_req_pkt, i_dcache_rdata);
        i_dcache_ack = 1'b1;
        dc_wait = {$random(resp_seed)} % 6;
      end else begin
        dc_wait--;
      end
    end
    if (i_nocache_ack) begin
      i_nocache_ack = 1'b0;
    end else if (o_nocache_req) begin
      if (nc_wait == 0) begin
        serve(o_nocache_req_pkt, i_nocache_rdata);
        i_nocache_ack = 1'b1;
        nc_wait = {$random(resp_seed)} % 6;
      end else begin
        nc_wait--;
      end
    end
  end

  task automatic serve(input mem_req_t r, output logic [63:0] rd);
    if (r.op) begin
      for (int b = 0; b <= int'(r.bytes); b++) begin
        dev_mem[r.addr + 64'(b)] = r.wdata[8*b +: 8];
      end
    end
    rd = read_bytes(1'b1, r.addr);
  endtask

  initial begin
    logic [63:0] cmp_addr;
    logic [63:0] time_addr;
    ex_pkt_t     p;
    mem_op_e     op;
    int          n;
    cmp_addr  = {32'd0, REGION_CLINT, 8'd0, CLINT_MTIMECMP_OFS};
    time_addr = {32'd0, REGION_CLINT, 8'd0, CLINT_MTIME_OFS};
    rst = 1'b1;
    i_ex_req = 1'b0;
    i_ex_pkt = '0;
    i_wb_ack = 1'b0;
    i_dcache_ack = 1'b0;
    i_dcache_rdata = 64'd0;
    i_nocache_ack = 1'b0;
    i_nocache_rdata = 64'd0;
    repeat (5) @(posedge clk);
    #1;
    rst = 1'b0;

    repeat (40) begin
      op = load_ops[{$random(seed)} % 7];
      issue(make_pkt(op, rand_addr(data_region(), access_bytes(op))));
    end
    wait_idle();
    report(1, "loads");

    repeat (25) begin
      n  = {$random(seed)} % 4;
      p  = make_pkt(store_ops[n], rand_addr(data_region(), access_bytes(store_ops[n])));
      issue(p);
      op = (n == 3) ? LD : load_ops[2 * n + ({$random(seed)} % 2)];
      issue(make_pkt(op, p.op1 + p.op3));
    end
    wait_idle();
    report(2, "store readback");

    repeat (30) begin
      case ({$random(seed)} % 4)
        0: issue(make_pkt(ALU, rand_addr(data_region(), 8)));
        1: issue(make_pkt(load_ops[{$random(seed)} % 7], rand_addr(8'h55, 8)));
        2: issue(make_pkt(store_ops[{$random(seed)} % 4], rand_addr(8'hc4, 8)));
        default: issue(make_pkt(LD, time_addr));
      endcase
    end
    wait_idle();
    report(3, "routing");

    // compare value with top bit set keeps the irq low
    p = make_pkt(SD, cmp_addr);
    p.op2[63] = 1'b1;
    issue(p);
    issue(make_pkt(LD, cmp_addr));
    issue(make_pkt(LD, time_addr));
    wait_idle();
    mtime_seen = last_wdata;
    issue(make_pkt(LD, time_addr));
    wait_idle();
    mtime_seen = last_wdata;
    if (o_timer_irq) begin
      $display("o_timer_irq high while mtimecmp is far above mtime");
      tb_errors++;
    end
    p = make_pkt(SD, cmp_addr);
    p.op2 = mtime_seen + 64'd20;
    issue(p);
    wait_idle();
    n = 0;
    while (!o_timer_irq && n < 200) begin
      @(posedge clk);
      #1;
      n++;
    end
    if (!o_timer_irq) begin
      $display("o_timer_irq did not rise after mtimecmp was set near mtime");
      tb_errors++;
    end
    report(4, "timer");

    stall_pct = 75;
    random_mix(40);
    wait_idle();
    stall_pct = 25;
    if (chk_handshakes != issued) begin
      $display("issued %0d instructions but saw %0d write-backs", issued, chk_handshakes);
      tb_errors++;
    end
    report(5, "back-pressure");

    $display("issued %0d, write-backs %0d, errors %0d", issued, chk_handshakes,
             chk_errors + tb_errors);
    if (chk_errors + tb_errors == 0) begin
      $display("RESULT: PASS");
    end else begin
      $display("RESULT: FAIL");
    end
    $finish;
  end

endmodule

//--- bench/mem_checker.sv
/* Expected results are pushed in issue order by the testbench.
   Port requests are compared at their ack, write-back packets at their handshake. */
`timescale 1ns/1ps

module mem_checker import mem_pkg::*; (
  input  logic        clk,
  input  logic        rst,
  input  logic        i_ex_ack,
  input  logic        i_wb_req,
  input  wb_pkt_t     i_wb_pkt,
  input  logic        i_wb_ack,
  input  logic        i_dc_req,
  input  mem_req_t    i_dc_pkt,
  input  logic        i_dc_ack,
  input  logic        i_nc_req,
  input  mem_req_t    i_nc_pkt,
  input  logic        i_nc_ack,
  output int          o_errors,
  output int          o_handshakes,
  output logic [63:0] o_last_wdata
);

  wb_pkt_t     wb_q[$];
  bit          ge_q[$];
  mem_req_t    port_q[$];
  bit          dc_q[$];
  int          err_cnt = 0;
  int          hs_cnt = 0;
  logic [63:0] last_wdata = 64'd0;
  logic        stalled = 1'b0;
  wb_pkt_t     held;

  assign o_errors     = err_cnt;
  assign o_handshakes = hs_cnt;
  assign o_last_wdata = last_wdata;

  // ge set means rd_wdata only has a lower bound (mtime reads)
  task automatic push_result(input wb_pkt_t p, input bit ge);
    wb_q.push_back(p);
    ge_q.push_back(ge);
  endtask

  task automatic push_port(input mem_req_t r, input bit dc);
    port_q.push_back(r);
    dc_q.push_back(dc);
  endtask

  task automatic check_port(input mem_req_t got, input bit dc);
    mem_req_t exp;
    bit       exp_dc;
    if (port_q.size() == 0) begin
      $display("unexpected request on the %s port at %0t", dc ? "cached" : "uncached", $time);
      err_cnt++;
    end else begin
      exp    = port_q.pop_front();
      exp_dc = dc_q.pop_front();
      if (exp_dc != dc) begin
        $display("request for %h went to the wrong port at %0t", got.addr, $time);
        err_cnt++;
      end
      if (got != exp) begin
        $display("ERROR t=%0t %s got %h exp %h", $time,
                 dc ? "o_dcache_req_pkt" : "o_nocache_req_pkt", got, exp);
        err_cnt++;
      end
    end
  endtask

  task automatic check_result(input wb_pkt_t got);
    wb_pkt_t exp;
    bit      ge;
    if (wb_q.size() == 0) begin
      $display("write-back handshake at %0t with no instruction outstanding", $time);
      err_cnt++;
    end else begin
      exp = wb_q.pop_front();
      ge  = ge_q.pop_front();
      if (ge && got.rd_wdata >= exp.rd_wdata) begin
        exp.rd_wdata = got.rd_wdata;
      end
      if (got.rd_wdata != exp.rd_wdata) begin
        $display("ERROR t=%0t o_wb_pkt.rd_wdata got %h exp %h", $time,
                 got.rd_wdata, exp.rd_wdata);
        err_cnt++;
      end else if (got != exp) begin
        $display("ERROR t=%0t o_wb_pkt got %h exp %h", $time, got, exp);
        err_cnt++;
      end
    end
    last_wdata = got.rd_wdata;
  endtask

  always @(posedge clk) begin
    if (rst) begin
      stalled <= 1'b0;
    end else begin
      if (stalled && (!i_wb_req || i_wb_pkt != held)) begin
        $display("write-back packet dropped or changed during a stall at %0t", $time);
        err_cnt++;
      end
      if (i_wb_req && i_ex_ack) begin
        $display("execute ack high while a result waits at %0t", $time);
        err_cnt++;
      end
      if (i_dc_req && i_nc_req) begin
        $display("both data ports requested at %0t", $time);
        err_cnt++;
      end
      stalled <= i_wb_req && !i_wb_ack;
      held    <= i_wb_pkt;
      if (i_wb_req && i_wb_ack) begin
        hs_cnt++;
        check_result(i_wb_pkt);
      end
      if (i_dc_req && i_dc_ack) begin
        check_port(i_dc_pkt, 1'b1);
      end
      if (i_nc_req && i_nc_ack) begin
        check_port(i_nc_pkt, 1'b0);
      end
    end
  end

endmodule

//--- hdl/mem_subsys_top.sv
/* Memory stage with its data-port arbiter and timer block.
   TIMER_DIV sets the mtime rate in clocks per count. */
`timescale 1ns/1ps

module mem_subsys_top import mem_pkg::*; #(
  parameter int TIMER_DIV = 1
) (
  input  logic        clk,
  input  logic        rst,
  input  logic        i_ex_req,
  input  ex_pkt_t     i_ex_pkt,
  output logic        o_ex_ack,
  output logic        o_wb_req,
  output wb_pkt_t     o_wb_pkt,
  input  logic        i_wb_ack,
  output logic        o_dcache_req,
  output mem_req_t    o_dcache_req_pkt,
  input  logic        i_dcache_ack,
  input  logic [63:0] i_dcache_rdata,
  output logic        o_nocache_req,
  output mem_req_t    o_nocache_req_pkt,
  input  logic        i_nocache_ack,
  input  logic [63:0] i_nocache_rdata,
  output logic        o_timer_irq
);

  logic        port_start;
  mem_req_t    port_req;
  logic        port_done;
  logic [63:0] port_rdata;
  logic        clint_strobe;
  logic        clint_we;
  logic [15:0] clint_ofs;
  logic [63:0] clint_wdata;
  logic [63:0] clint_rdata;

  mem_stage u_stage (
    .clk            (clk),
    .rst            (rst),
    .i_ex_req       (i_ex_req),
    .i_ex_pkt       (i_ex_pkt),
    .o_ex_ack       (o_ex_ack),
    .o_wb_req       (o_wb_req),
    .o_wb_pkt       (o_wb_pkt),
    .i_wb_ack       (i_wb_ack),
    .o_port_start   (port_start),
    .o_port_req     (port_req),
    .i_port_done    (port_done),
    .i_port_rdata   (port_rdata),
    .o_clint_strobe (clint_strobe),
    .o_clint_we     (clint_we),
    .o_clint_ofs    (clint_ofs),
    .o_clint_wdata  (clint_wdata),
    .i_clint_rdata  (clint_rdata)
  );

  mem_port_arb u_arb (
    .clk               (clk),
    .rst               (rst),
    .i_start           (port_start),
    .i_req             (port_req),
    .o_done            (port_done),
    .o_rdata           (port_rdata),
    .o_dcache_req      (o_dcache_req),
    .o_dcache_req_pkt  (o_dcache_req_pkt),
    .i_dcache_ack      (i_dcache_ack),
    .i_dcache_rdata    (i_dcache_rdata),
    .o_nocache_req     (o_nocache_req),
    .o_nocache_req_pkt (o_nocache_req_pkt),
    .i_nocache_ack     (i_nocache_ack),
    .i_nocache_rdata   (i_nocache_rdata)
  );

  clint_regs #(
    .TIMER_DIV (TIMER_DIV)
  ) u_clint (
    .clk         (clk),
    .rst         (rst),
    .i_strobe    (clint_strobe),
    .i_we        (clint_we),
    .i_ofs       (clint_ofs),
    .i_wdata     (clint_wdata),
    .o_rdata     (clint_rdata),
    .o_timer_irq (o_timer_irq)
  );

endmodule

//--- hdl/clint_regs.sv
/* Only mtime and mtimecmp exist, written and read as whole 64-bit words.
   Reads are combinational, other offsets read as zero. */
`timescale 1ns/1ps

module clint_regs import mem_pkg::*; #(
  parameter int TIMER_DIV = 1
) (
  input  logic        clk,
  input  logic        rst,
  input  logic        i_strobe,
  input  logic        i_we,
  input  logic [15:0] i_ofs,
  input  logic [63:0] i_wdata,
  output logic [63:0] o_rdata,
  output logic        o_timer_irq
);

  localparam int DIV_W = (TIMER_DIV > 1) ? $clog2(TIMER_DIV) : 1;
  localparam logic [DIV_W-1:0] DIV_LAST = DIV_W'(TIMER_DIV - 1);

  logic [DIV_W-1:0] div_cnt;
  logic             tick;
  logic [63:0]      mtime;
  logic [63:0]      mtimecmp;
  logic             wr_mtime;
  logic             wr_mtimecmp;
  logic             irq_q;

  assign tick        = (div_cnt == DIV_LAST);
  assign wr_mtime    = i_strobe & i_we & (i_ofs == CLINT_MTIME_OFS);
  assign wr_mtimecmp = i_strobe & i_we & (i_ofs == CLINT_MTIMECMP_OFS);

  // prescaler for mtime
  always_ff @(posedge clk) begin
    if (rst || tick) begin
      div_cnt <= '0;
    end else begin
      div_cnt <= div_cnt + 1'b1;
    end
  end

  always_ff @(posedge clk) begin
    if (rst) begin
      mtime <= 64'd0;
    end else if (wr_mtime) begin
      mtime <= i_wdata;
    end else if (tick) begin
      mtime <= mtime + 64'd1;
    end
  end

  // all ones so no irq fires before software sets a compare value
  always_ff @(posedge clk) begin
    if (rst) begin
      mtimecmp <= '1;
    end else if (wr_mtimecmp) begin
      mtimecmp <= i_wdata;
    end
  end

  always_ff @(posedge clk) begin
    if (rst) begin
      irq_q <= 1'b0;
    end else begin
      irq_q <= (mtime >= mtimecmp);
    end
  end

  assign o_timer_irq = irq_q;

  always_comb begin
    case (i_ofs)
      CLINT_MTIME_OFS:    o_rdata = mtime;
      CLINT_MTIMECMP_OFS: o_rdata = mtimecmp;
      default:            o_rdata = 64'd0;
    endcase
  end

  a_mtime_mono: assert property (@(posedge clk) disable iff (rst)
    !wr_mtime |=> mtime >= $past(mtime))
    else $error("mtime went backwards without a write");

endmodule

//--- hdl/mem_port_arb.sv
/* Single outstanding access. Port choice uses address bits 31:24 only,
   region 0x80 is cached and all else goes uncached. */
`timescale 1ns/1ps

module mem_port_arb import mem_pkg::*; (
  input  logic        clk,
  input  logic        rst,
  input  logic        i_start,
  input  mem_req_t    i_req,
  output logic        o_done,
  output logic [63:0] o_rdata,
  output logic        o_dcache_req,
  output mem_req_t    o_dcache_req_pkt,
  input  logic        i_dcache_ack,
  input  logic [63:0] i_dcache_rdata,
  output logic        o_nocache_req,
  output mem_req_t    o_nocache_req_pkt,
  input  logic        i_nocache_ack,
  input  logic [63:0] i_nocache_rdata
);

  logic        dc_req;
  logic        nc_req;
  logic        done_q;
  mem_req_t    req_q;
  logic [63:0] rdata_q;

  always_ff @(posedge clk) begin
    if (rst) begin
      dc_req <= 1'b0;
      nc_req <= 1'b0;
      done_q <= 1'b0;
    end else begin
      done_q <= 1'b0;
      if (i_start) begin
        if (i_req.addr[31:24] == REGION_DCACHE) begin
          dc_req <= 1'b1;
        end else begin
          nc_req <= 1'b1;
        end
      end
      if (dc_req & i_dcache_ack) begin
        dc_req <= 1'b0;
        done_q <= 1'b1;
      end
      if (nc_req & i_nocache_ack) begin
        nc_req <= 1'b0;
        done_q <= 1'b1;
      end
    end
  end

  // request payload and returned data
  always_ff @(posedge clk) begin
    if (i_start) begin
      req_q <= i_req;
    end
    if (dc_req & i_dcache_ack) begin
      rdata_q <= i_dcache_rdata;
    end else if (nc_req & i_nocache_ack) begin
      rdata_q <= i_nocache_rdata;
    end
  end

  assign o_dcache_req      = dc_req;
  assign o_nocache_req     = nc_req;
  assign o_dcache_req_pkt  = req_q;
  assign o_nocache_req_pkt = req_q;
  assign o_done            = done_q;
  assign o_rdata           = rdata_q;

  a_one_port: assert property (@(posedge clk) disable iff (rst)
    !(o_dcache_req && o_nocache_req))
    else $error("both data ports requested at once");

  a_dc_hold: assert property (@(posedge clk) disable iff (rst)
    o_dcache_req && !i_dcache_ack |=> o_dcache_req && $stable(o_dcache_req_pkt))
    else $error("cached request dropped or changed before ack");

  a_nc_hold: assert property (@(posedge clk) disable iff (rst)
    o_nocache_req && !i_nocache_ack |=> o_nocache_req && $stable(o_nocache_req_pkt))
    else $error("uncached request dropped or changed before ack");

endmodule

//--- hdl/mem_stage.sv
/* One instruction in flight. Unmapped loads return zero before extension,
   and timer reads return the whole 64-bit register at its offset. */
`timescale 1ns/1ps

module mem_stage import mem_pkg::*; (
  input  logic        clk,
  input  logic        rst,
  input  logic        i_ex_req,
  input  ex_pkt_t     i_ex_pkt,
  output logic        o_ex_ack,
  output logic        o_wb_req,
  output wb_pkt_t     o_wb_pkt,
  input  logic        i_wb_ack,
  output logic        o_port_start,
  output mem_req_t    o_port_req,
  input  logic        i_port_done,
  input  logic [63:0] i_port_rdata,
  output logic        o_clint_strobe,
  output logic        o_clint_we,
  output logic [15:0] o_clint_ofs,
  output logic [63:0] o_clint_wdata,
  input  logic [63:0] i_clint_rdata
);

  logic        busy;
  logic        port_wait;
  logic        wb_valid;
  logic        accept;
  logic        wb_hs;

  logic        rd_en;
  logic        wr_en;
  logic [2:0]  size;
  logic [63:0] addr;
  logic [7:0]  region;
  logic [63:0] st_data;
  logic        ch_port;
  logic        ch_clint;

  wb_pkt_t     base_q;
  mem_op_e     op_q;
  logic        ch_port_q;
  logic        ch_clint_q;
  logic [63:0] clint_rdata_q;
  logic [63:0] rdata;
  logic [63:0] wb_data;

  assign o_ex_ack = ~busy;
  assign accept   = i_ex_req & o_ex_ack;
  assign o_wb_req = wb_valid | (port_wait & i_port_done);
  assign wb_hs    = o_wb_req & i_wb_ack;

  // op decode
  always_comb begin
    rd_en = 1'b0;
    wr_en = 1'b0;
    size  = 3'd0;
    case (i_ex_pkt.op)
      LB, LBU: rd_en = 1'b1;
      LH, LHU: begin
        rd_en = 1'b1;
        size  = 3'd1;
      end
      LW, LWU: begin
        rd_en = 1'b1;
        size  = 3'd3;
      end
      LD: begin
        rd_en = 1'b1;
        size  = 3'd7;
      end
      SB: wr_en = 1'b1;
      SH: begin
        wr_en = 1'b1;
        size  = 3'd1;
      end
      SW: begin
        wr_en = 1'b1;
        size  = 3'd3;
      end
      SD: begin
        wr_en = 1'b1;
        size  = 3'd7;
      end
      default: ;
    endcase
  end

  assign addr   = i_ex_pkt.op1 + i_ex_pkt.op3;
  assign region = addr[31:24];

  always_comb begin
    case (size)
      3'd0:    st_data = {56'd0, i_ex_pkt.op2[7:0]};
      3'd1:    st_data = {48'd0, i_ex_pkt.op2[15:0]};
      3'd3:    st_data = {32'd0, i_ex_pkt.op2[31:0]};
      default: st_data = i_ex_pkt.op2;
    endcase
  end

  assign ch_port  = (rd_en | wr_en) &
                    (region == REGION_DCACHE || region == REGION_NOCACHE_A ||
                     region == REGION_NOCACHE_B);
  assign ch_clint = (rd_en | wr_en) & (region == REGION_CLINT);

  assign o_port_start     = accept & ch_port;
  assign o_port_req.addr  = addr;
  assign o_port_req.op    = wr_en;
  assign o_port_req.bytes = size;
  assign o_port_req.wdata = st_data;

  // timer registers are accessed in the acceptance cycle
  assign o_clint_strobe = accept & ch_clint;
  assign o_clint_we     = wr_en;
  assign o_clint_ofs    = addr[15:0];
  assign o_clint_wdata  = st_data;

  always_ff @(posedge clk) begin
    if (rst) begin
      busy      <= 1'b0;
      port_wait <= 1'b0;
      wb_valid  <= 1'b0;
    end else begin
      if (accept) begin
        busy <= 1'b1;
        if (ch_port) begin
          port_wait <= 1'b1;
        end else begin
          wb_valid <= 1'b1;
        end
      end
      if (port_wait & i_port_done) begin
        port_wait <= 1'b0;
        wb_valid  <= ~i_wb_ack;
      end
      if (wb_hs) begin
        busy <= 1'b0;
        if (wb_valid) begin
          wb_valid <= 1'b0;
        end
      end
    end
  end

  always_ff @(posedge clk) begin
    if (accept) begin
      base_q.pc       <= i_ex_pkt.pc;
      base_q.inst     <= i_ex_pkt.inst;
      base_q.rd       <= i_ex_pkt.rd;
      base_q.rd_wen   <= i_ex_pkt.rd_wen;
      base_q.rd_wdata <= i_ex_pkt.rd_wdata;
      base_q.nocmt    <= i_ex_pkt.nocmt;
      base_q.skipcmt  <= i_ex_pkt.skipcmt;
      op_q            <= i_ex_pkt.op;
      ch_port_q       <= ch_port;
      ch_clint_q      <= ch_clint;
      clint_rdata_q   <= i_clint_rdata;
    end
  end

  always_comb begin
    if (ch_clint_q) begin
      rdata = clint_rdata_q;
    end else if (ch_port_q) begin
      rdata = i_port_rdata;
    end else begin
      rdata = 64'd0;
    end
  end

  // load extension, everything else passes rd_wdata
  always_comb begin
    case (op_q)
      LB:      wb_data = {{56{rdata[7]}}, rdata[7:0]};
      LBU:     wb_data = {56'd0, rdata[7:0]};
      LH:      wb_data = {{48{rdata[15]}}, rdata[15:0]};
      LHU:     wb_data = {48'd0, rdata[15:0]};
      LW:      wb_data = {{32{rdata[31]}}, rdata[31:0]};
      LWU:     wb_data = {32'd0, rdata[31:0]};
      LD:      wb_data = rdata;
      default: wb_data = base_q.rd_wdata;
    endcase
  end

  always_comb begin
    o_wb_pkt          = base_q;
    o_wb_pkt.rd_wdata = wb_data;
    o_wb_pkt.skipcmt  = base_q.skipcmt | ch_clint_q;
  end

  // a port done with nothing held would emit a stale result
  a_wb_needs_inst: assert property (@(posedge clk) disable iff (rst)
    $rose(o_wb_req) |-> busy)
    else $error("write-back request raised with no instruction held");

endmodule

//--- hdl/mem_pkg.sv
/* Shared types for the memory stage. Accesses are assumed naturally aligned,
   and only address bits 31:24 take part in region decoding. */

package mem_pkg;

  // operation codes from execute, anything unlisted behaves as ALU
  typedef enum logic [7:0] {
    ALU = 8'h00,
    LB  = 8'h01,
    LBU = 8'h02,
    LH  = 8'h03,
    LHU = 8'h04,
    LW  = 8'h05,
    LWU = 8'h06,
    LD  = 8'h07,
    SB  = 8'h08,
    SH  = 8'h09,
    SW  = 8'h0a,
    SD  = 8'h0b
  } mem_op_e;

  typedef struct packed {
    logic [63:0] pc;
    logic [31:0] inst;
    logic [4:0]  rd;
    logic        rd_wen;
    logic [63:0] rd_wdata;
    logic        nocmt;
    logic        skipcmt;
    mem_op_e     op;
    logic [63:0] op1;
    logic [63:0] op2;
    logic [63:0] op3;
  } ex_pkt_t;

  typedef struct packed {
    logic [63:0] pc;
    logic [31:0] inst;
    logic [4:0]  rd;
    logic        rd_wen;
    logic [63:0] rd_wdata;
    logic        nocmt;
    logic        skipcmt;
  } wb_pkt_t;

  // bytes holds size minus one, op high for a write
  typedef struct packed {
    logic [63:0] addr;
    logic        op;
    logic [2:0]  bytes;
    logic [63:0] wdata;
  } mem_req_t;

  // address bits 31:24
  localparam logic [7:0] REGION_DCACHE    = 8'h80;
  localparam logic [7:0] REGION_NOCACHE_A = 8'h10;
  localparam logic [7:0] REGION_NOCACHE_B = 8'h30;
  localparam logic [7:0] REGION_CLINT     = 8'h02;

  localparam logic [15:0] CLINT_MTIMECMP_OFS = 16'h4000;
  localparam logic [15:0] CLINT_MTIME_OFS    = 16'hbff8;

endpackage
